//--- dv/uart_tb.sv
// Runs at divisor 4 only; the bit-banger and the timeout assume that rate
`default_nettype none
`timescale 1ns/1ps

module uart_tb;
    import uart_pkg::*;
    import uart_axi_pkg::*;

    localparam int TEST_DIV = 4;
    localparam int BIT_CLKS = TEST_DIV * OVERSAMPLE;
    // Loopback, parity, framing, overrun and transmit FIFO frames
    localparam int FRAMES       = 3 * 20 + 6 + 1 + 9 + 9;
    localparam int TIMEOUT_CLKS = FRAMES * 12 * BIT_CLKS + 12500;

    logic        clk;
    logic        rst_n;
    axil_req_t   axil_req;
    axil_rsp_t   axil_rsp;
    logic        rx_line;
    logic        tx_line;
    logic        bb_line;
    logic        use_loop;
    logic [31:0] seed;
    int          errors = 0;

    // Line mux, loopback or bit-banger
    assign rx_line = use_loop ? tx_line : bb_line;

    uart_top u_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .axil_req (axil_req),
        .axil_rsp (axil_rsp),
        .rx       (rx_line),
        .tx       (tx_line)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic end_with_failure();
        errors++;
        $display("Test failed");
        $fatal(1, "Stopping at first error");
    endtask

    task automatic check_eq(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("MISMATCH %s expected 0x%08h actual 0x%08h", name, expected, actual);
            end_with_failure();
        end
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Parity bit that makes the ones count odd or even
    function automatic logic parity_bit(input logic [7:0] data, input parity_mode_e mode);
        return (mode == PARITY_ODD) ? ~^data : ^data;
    endfunction

    // DATA register image of a received frame
    function automatic logic [31:0] data_word(input logic [7:0] data, input logic pe,
                                              input logic fe);
        return {1'b1, 21'd0, fe, pe, data};
    endfunction

    task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        @(posedge clk);
        axil_req.awvalid <= 1'b1;
        axil_req.awaddr  <= addr;
        axil_req.wvalid  <= 1'b1;
        axil_req.wdata   <= data;
        axil_req.wstrb   <= 4'hf;
        @(negedge clk);
        while (!axil_rsp.awready) begin
            @(negedge clk);
        end
        check_eq("write_wready", 32'd1, 32'(axil_rsp.wready));
        @(posedge clk);
        axil_req.awvalid <= 1'b0;
        axil_req.wvalid  <= 1'b0;
        @(negedge clk);
        while (!axil_rsp.bvalid) begin
            @(negedge clk);
        end
        resp = axil_rsp.bresp;
        @(posedge clk);
    endtask

    task automatic axi_read(input logic [3:0] addr, output logic [31:0] data);
        @(posedge clk);
        axil_req.arvalid <= 1'b1;
        axil_req.araddr  <= addr;
        @(negedge clk);
        while (!axil_rsp.arready) begin
            @(negedge clk);
        end
        @(posedge clk);
        axil_req.arvalid <= 1'b0;
        @(negedge clk);
        while (!axil_rsp.rvalid) begin
            @(negedge clk);
        end
        data = axil_rsp.rdata;
        @(posedge clk);
    endtask

    task automatic write_ctrl(input parity_mode_e mode);
        logic [1:0] resp;
        axi_write(REG_CTRL, {16'(TEST_DIV), 14'd0, mode}, resp);
        check_eq("ctrl_write_resp", 32'(RESP_OKAY), 32'(resp));
    endtask

    // Polls STATUS until rx_empty drops
    task automatic wait_rx_data();
        logic [31:0] status;
        axi_read(REG_STATUS, status);
        while (status[2]) begin
            axi_read(REG_STATUS, status);
        end
    endtask

    // Start, data LSB first, optional parity, stop, then one idle bit
    task automatic send_frame(input logic [7:0] data, input logic par_en,
                              input logic par_val, input logic stop_val);
        logic [10:0] bits;
        int          nbits;
        bits  = par_en ? {stop_val, par_val, data, 1'b0} : {1'b1, stop_val, data, 1'b0};
        nbits = par_en ? 11 : 10;
        for (int i = 0; i < nbits; i++) begin
            @(posedge clk);
            bb_line <= bits[i];
            repeat (BIT_CLKS - 1) @(posedge clk);
        end
        @(posedge clk);
        bb_line <= 1'b1;
        repeat (BIT_CLKS - 1) @(posedge clk);
    endtask

    // Write held with bready low while a second write waits
    task automatic hold_write_response();
        @(posedge clk);
        axil_req.bready  <= 1'b0;
        axil_req.awvalid <= 1'b1;
        axil_req.awaddr  <= REG_CTRL;
        axil_req.wvalid  <= 1'b1;
        axil_req.wdata   <= {16'(TEST_DIV), 16'd0};
        axil_req.wstrb   <= 4'hf;
        @(negedge clk);
        while (!axil_rsp.awready) begin
            @(negedge clk);
        end
        repeat (8) begin
            @(negedge clk);
            check_eq("held_bvalid", 32'd1, 32'(axil_rsp.bvalid));
            check_eq("held_bresp", 32'(RESP_OKAY), 32'(axil_rsp.bresp));
            check_eq("held_awready", 32'd0, 32'(axil_rsp.awready));
            check_eq("held_wready", 32'd0, 32'(axil_rsp.wready));
        end
        @(posedge clk);
        axil_req.awvalid <= 1'b0;
        axil_req.wvalid  <= 1'b0;
        axil_req.bready  <= 1'b1;
        @(negedge clk);
        while (axil_rsp.bvalid) begin
            @(negedge clk);
        end
    endtask

    task automatic hold_read_response();
        logic [31:0] first;
        @(posedge clk);
        axil_req.rready  <= 1'b0;
        axil_req.arvalid <= 1'b1;
        axil_req.araddr  <= REG_STATUS;
        @(negedge clk);
        while (!axil_rsp.arready) begin
            @(negedge clk);
        end
        @(negedge clk);
        first = axil_rsp.rdata;
        check_eq("held_status_value", 32'h0000_0006, first);
        repeat (8) begin
            @(negedge clk);
            check_eq("held_rvalid", 32'd1, 32'(axil_rsp.rvalid));
            check_eq("held_arready", 32'd0, 32'(axil_rsp.arready));
            check_eq("held_rdata", 32'h0000_0006, axil_rsp.rdata);
        end
        @(posedge clk);
        axil_req.arvalid <= 1'b0;
        axil_req.rready  <= 1'b1;
        @(negedge clk);
        while (axil_rsp.rvalid) begin
            @(negedge clk);
        end
    endtask

    initial begin
        repeat (TIMEOUT_CLKS) @(posedge clk);
        $display("Timeout: no result after %0d clock cycles", TIMEOUT_CLKS);
        end_with_failure();
    end

    initial begin
        logic [1:0]   resp;
        logic [31:0]  rd;
        logic [7:0]   b;
        logic [7:0]   sent [9];
        parity_mode_e mode;

        rst_n           <= 1'b0;
        axil_req        <= '0;
        axil_req.bready <= 1'b1;
        axil_req.rready <= 1'b1;
        bb_line         <= 1'b1;
        use_loop        <= 1'b0;
        seed = 32'hcc3;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        // Reset values
        @(negedge clk);
        check_eq("reset_tx_idle", 32'd1, 32'(tx_line));
        axi_read(REG_STATUS, rd);
        check_eq("reset_status", 32'h0000_0006, rd);
        axi_read(REG_CTRL, rd);
        check_eq("reset_ctrl", 32'h0001_0000, rd);

        // Loopback in none, odd and even
        for (int m = 0; m < 3; m++) begin
            mode = parity_mode_e'(2'(m));
            write_ctrl(mode);
            use_loop <= 1'b1;
            for (int i = 0; i < 20; i++) begin
                seed = lcg_next(seed);
                b    = seed[23:16];
                axi_write(REG_DATA, {24'd0, b}, resp);
                check_eq("loopback_write_resp", 32'(RESP_OKAY), 32'(resp));
                wait_rx_data();
                axi_read(REG_DATA, rd);
                check_eq($sformatf("loopback_mode%0d_byte%0d", m, i),
                         data_word(b, 1'b0, 1'b0), rd);
            end
        end

        // Inverted parity bit from the bit-banger
        use_loop <= 1'b0;
        for (int m = 1; m < 3; m++) begin
            mode = parity_mode_e'(2'(m));
            write_ctrl(mode);
            for (int i = 0; i < 2; i++) begin
                seed = lcg_next(seed);
                b    = seed[23:16];
                send_frame(b, 1'b1, ~parity_bit(b, mode), 1'b1);
                wait_rx_data();
                axi_read(REG_DATA, rd);
                check_eq($sformatf("parity_err_mode%0d", m), data_word(b, 1'b1, 1'b0), rd);
            end
        end
        write_ctrl(PARITY_NONE);
        for (int i = 0; i < 2; i++) begin
            seed = lcg_next(seed);
            b    = seed[23:16];
            send_frame(b, 1'b0, 1'b0, 1'b1);
            wait_rx_data();
            axi_read(REG_DATA, rd);
            check_eq("parity_none_good", data_word(b, 1'b0, 1'b0), rd);
        end

        // Low stop bit
        seed = lcg_next(seed);
        b    = seed[23:16];
        send_frame(b, 1'b0, 1'b0, 1'b0);
        wait_rx_data();
        axi_read(REG_DATA, rd);
        check_eq("frame_err", data_word(b, 1'b0, 1'b1), rd);

        // Nine frames into an eight-entry FIFO
        for (int i = 0; i < 9; i++) begin
            seed    = lcg_next(seed);
            sent[i] = seed[23:16];
            send_frame(sent[i], 1'b0, 1'b0, 1'b1);
        end
        axi_read(REG_STATUS, rd);
        check_eq("overrun_status", 32'h0000_000a, rd);
        for (int i = 0; i < 8; i++) begin
            axi_read(REG_DATA, rd);
            check_eq($sformatf("overrun_entry%0d", i), data_word(sent[i], 1'b0, 1'b0), rd);
        end
        axi_read(REG_DATA, rd);
        check_eq("empty_read_valid_bit", 32'd0, 32'(rd[31]));
        axi_write(REG_STATUS, 32'h0000_0008, resp);
        axi_read(REG_STATUS, rd);
        check_eq("overrun_cleared", 32'h0000_0006, rd);

        // One byte in the transmitter plus eight queued, the tenth is dropped
        for (int i = 0; i < 10; i++) begin
            seed = lcg_next(seed);
            axi_write(REG_DATA, {24'd0, seed[23:16]}, resp);
            check_eq($sformatf("tx_write%0d_resp", i),
                     (i < 9) ? 32'(RESP_OKAY) : 32'(RESP_SLVERR), 32'(resp));
        end
        axi_read(REG_STATUS, rd);
        check_eq("tx_full_status", 32'h0000_0015, rd);
        axi_read(REG_STATUS, rd);
        while (rd[4] || !rd[1]) begin
            axi_read(REG_STATUS, rd);
        end
        check_eq("tx_drained_status", 32'h0000_0006, rd);

        // Back-pressure on both response channels
        hold_write_response();
        hold_read_response();
        axi_read(REG_CTRL, rd);
        check_eq("ctrl_after_hold", 32'h0004_0000, rd);

        if (errors == 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            end_with_failure();
        end
    end

endmodule

`default_nettype wire

//--- dv/uart_tb_sva.sv
// Protocol assertions for uart_top, bound from outside; responses are checked only after reset
`default_nettype none
`timescale 1ns/1ps

module uart_tb_sva (
    input logic                    clk,
    input logic                    rst_n,
    input uart_axi_pkg::axil_req_t axil_req,
    input uart_axi_pkg::axil_rsp_t axil_rsp,
    input logic                    tx
);
    import uart_axi_pkg::*;

    // Write response held until bready
    a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid && $stable(axil_rsp.bresp))
        else $error("bvalid dropped or bresp changed before bready");

    // Read response held with stable data until rready
    a_rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid && $stable(axil_rsp.rdata))
        else $error("rvalid dropped or rdata changed before rready");

    a_awready_req: assert property (@(posedge clk) disable iff (!rst_n)
        axil_rsp.awready |-> axil_req.awvalid && axil_req.wvalid)
        else $error("awready without awvalid and wvalid");

    a_arready_req: assert property (@(posedge clk) disable iff (!rst_n)
        axil_rsp.arready |-> axil_req.arvalid)
        else $error("arready without arvalid");

    a_rresp_okay: assert property (@(posedge clk) disable iff (!rst_n)
        axil_rsp.rvalid |-> axil_rsp.rresp == RESP_OKAY)
        else $error("read response other than OKAY");

    // Line idles high out of reset
    a_tx_reset: assert property (@(posedge clk) !rst_n |=> tx)
        else $error("tx not high after reset");

    a_rsp_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> !axil_rsp.bvalid && !axil_rsp.rvalid)
        else $error("response valid right after reset");

endmodule

bind uart_top uart_tb_sva u_sva (
    .clk      (clk),
    .rst_n    (rst_n),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp),
    .tx       (tx)
);

`default_nettype wire

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module uart_tb -f uart_top.f -o uart_tb_sim
./obj_dir/uart_tb_sim | tee sim.log

if grep -q "Test failed" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
if ! grep -q "Test completed successfully" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation passed"

//--- uart_top.f
verilog/uart_pkg.sv
verilog/uart_axi_pkg.sv
verilog/uart_baud_gen.sv
verilog/uart_rx.sv
verilog/uart_tx.sv
verilog/uart_fifo.sv
verilog/uart_regs.sv
verilog/uart_top.sv
dv/uart_tb_sva.sv
dv/uart_tb.sv

//--- verilog/uart_axi_pkg.sv
// AXI4-Lite channel bundles for a 4-bit address, 32-bit data slave; no burst or protection signals
`default_nettype none

package uart_axi_pkg;

    localparam int AXIL_AW = 4;
    localparam int AXIL_DW = 32;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // Register offsets
    localparam logic [AXIL_AW-1:0] REG_DATA   = 4'h0;
    localparam logic [AXIL_AW-1:0] REG_STATUS = 4'h4;
    localparam logic [AXIL_AW-1:0] REG_CTRL   = 4'h8;

    // Master to slave
    typedef struct packed {
        logic                 awvalid;
        logic [AXIL_AW-1:0]   awaddr;
        logic                 wvalid;
        logic [AXIL_DW-1:0]   wdata;
        logic [AXIL_DW/8-1:0] wstrb;
        logic                 bready;
        logic                 arvalid;
        logic [AXIL_AW-1:0]   araddr;
        logic                 rready;
    } axil_req_t;

    // Slave to master
    typedef struct packed {
        logic               awready;
        logic               wready;
        logic               bvalid;
        logic [1:0]         bresp;
        logic               arready;
        logic               rvalid;
        logic [AXIL_DW-1:0] rdata;
        logic [1:0]         rresp;
    } axil_rsp_t;

endpackage

`default_nettype wire

//--- verilog/uart_baud_gen.sv
// One-clk tick every divisor clocks, a divisor of 0 runs at the same rate as 1
`default_nettype none
`timescale 1ns/1ps

module uart_baud_gen (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [uart_pkg::DIV_W-1:0] divisor,
    output logic                       baud_tick
);
    import uart_pkg::*;

    logic [DIV_W-1:0] cnt;
    logic [DIV_W-1:0] reload;

    // Count runs divisor-1 down to 0
    assign reload = (divisor == '0) ? '0 : divisor - 1'b1;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt       <= '0;
            baud_tick <= 1'b0;
        end else if (cnt == '0) begin
            cnt       <= reload;
            baud_tick <= 1'b1;
        end else begin
            cnt       <= cnt - 1'b1;
            baud_tick <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- verilog/uart_fifo.sv
// Synchronous FIFO with first-word fall-through read data; DEPTH must be at least 2
`default_nettype none
`timescale 1ns/1ps

module uart_fifo #(
    parameter type entry_t = logic [7:0],
    parameter int  DEPTH   = 8
) (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   push_valid,
    input  entry_t push_data,
    output logic   push_ready,
    output logic   pop_valid,
    output entry_t pop_data,
    input  logic   pop_ready,
    output logic   empty,
    output logic   full
);
    localparam int AW = $clog2(DEPTH);

    entry_t        mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          push_fire;
    logic          pop_fire;

    assign full       = (count == (AW + 1)'(DEPTH));
    assign empty      = (count == '0);
    assign push_ready = !full;
    assign pop_valid  = !empty;
    assign pop_data   = mem[rd_ptr];
    assign push_fire  = push_valid && push_ready;
    assign pop_fire   = pop_valid && pop_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_fire) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_fire) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leave the count alone
            if (push_fire && !pop_fire) begin
                count <= count + 1'b1;
            end else if (pop_fire && !push_fire) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push_fire) begin
            mem[wr_ptr] <= push_data;
        end
    end

endmodule

`default_nettype wire

//--- verilog/uart_pkg.sv
// Line-side types shared by the receiver, transmitter and register block; eight data bits only
`default_nettype none

package uart_pkg;

    // Baud ticks per serial bit, must be a power of two
    localparam int OVERSAMPLE = 16;
    localparam int TICK_W     = $clog2(OVERSAMPLE);

    // Clock divisor width, CTRL bits 31:16
    localparam int DIV_W = 16;

    // FIFO depths
    localparam int RX_DEPTH = 8;
    localparam int TX_DEPTH = 8;

    // Code 3 is reserved and treated as no parity
    typedef enum logic [1:0] {
        PARITY_NONE = 2'd0,
        PARITY_ODD  = 2'd1,
        PARITY_EVEN = 2'd2
    } parity_mode_e;

    // Bit states on the line, shared by both directions
    typedef enum logic [2:0] {
        S_IDLE,
        S_START,
        S_DATA,
        S_PARITY,
        S_STOP
    } line_state_e;

    // Field order matches DATA register bits 9:0
    typedef struct packed {
        logic       frame_err;
        logic       parity_err;
        logic [7:0] data;
    } rx_frame_t;

endpackage

`default_nettype wire

//--- verilog/uart_regs.sv
// AXI4-Lite slave, one outstanding write and one read; unmapped offsets read 0 and ignore writes
`default_nettype none
`timescale 1ns/1ps

module uart_regs (
    input  logic                       clk,
    input  logic                       rst_n,
    input  uart_axi_pkg::axil_req_t    axil_req,
    output uart_axi_pkg::axil_rsp_t    axil_rsp,
    output uart_pkg::parity_mode_e     parity_mode,
    output logic [uart_pkg::DIV_W-1:0] divisor,
    output logic                       tx_push_valid,
    output logic [7:0]                 tx_push_data,
    input  logic                       tx_push_ready,
    input  logic                       tx_empty,
    input  logic                       tx_busy,
    input  logic                       rx_pop_valid,
    input  uart_pkg::rx_frame_t        rx_pop_data,
    output logic                       rx_pop_ready,
    input  logic                       rx_valid,
    input  logic                       rx_push_ready
);
    import uart_pkg::*;
    import uart_axi_pkg::*;

    logic               wr_fire;
    logic               rd_fire;
    logic               ctrl_wr;
    logic               bvalid;
    logic               rvalid;
    logic [1:0]         bresp;
    logic [AXIL_DW-1:0] rdata;
    logic [AXIL_DW-1:0] rdata_next;
    logic               overrun;

    // Ready is granted only while no response is held
    assign wr_fire = axil_req.awvalid && axil_req.wvalid && !bvalid;
    assign rd_fire = axil_req.arvalid && !rvalid;
    assign ctrl_wr = wr_fire && (axil_req.awaddr == REG_CTRL);

    assign tx_push_valid = wr_fire && (axil_req.awaddr == REG_DATA) && axil_req.wstrb[0];
    assign tx_push_data  = axil_req.wdata[7:0];
    assign rx_pop_ready  = rd_fire && (axil_req.araddr == REG_DATA);

    always_comb begin
        case (axil_req.araddr)
            REG_DATA:   rdata_next = {rx_pop_valid, 21'd0, rx_pop_data};
            REG_STATUS: rdata_next = {27'd0, tx_busy, overrun, !rx_pop_valid,
                                      tx_empty, !tx_push_ready};
            REG_CTRL:   rdata_next = {divisor, 14'd0, parity_mode};
            default:    rdata_next = '0;
        endcase
    end

    always_comb begin
        axil_rsp.awready = wr_fire;
        axil_rsp.wready  = wr_fire;
        axil_rsp.bvalid  = bvalid;
        axil_rsp.bresp   = bresp;
        axil_rsp.arready = rd_fire;
        axil_rsp.rvalid  = rvalid;
        axil_rsp.rdata   = rdata;
        axil_rsp.rresp   = RESP_OKAY;
    end

    // Response valid flags
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            if (wr_fire) begin
                bvalid <= 1'b1;
            end else if (axil_req.bready) begin
                bvalid <= 1'b0;
            end
            if (rd_fire) begin
                rvalid <= 1'b1;
            end else if (axil_req.rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // Response payloads
    always_ff @(posedge clk) begin
        if (wr_fire) begin
            // Byte dropped when the transmit FIFO is full
            bresp <= (tx_push_valid && !tx_push_ready) ? RESP_SLVERR : RESP_OKAY;
        end
        if (rd_fire) begin
            rdata <= rdata_next;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            parity_mode <= PARITY_NONE;
            divisor     <= DIV_W'(1);
            overrun     <= 1'b0;
        end else begin
            if (ctrl_wr && axil_req.wstrb[0]) begin
                parity_mode <= parity_mode_e'(axil_req.wdata[1:0]);
            end
            if (ctrl_wr && axil_req.wstrb[2]) begin
                divisor[7:0] <= axil_req.wdata[23:16];
            end
            if (ctrl_wr && axil_req.wstrb[3]) begin
                divisor[15:8] <= axil_req.wdata[31:24];
            end
            // A lost frame wins over a clear in the same cycle
            if (rx_valid && !rx_push_ready) begin
                overrun <= 1'b1;
            end else if (wr_fire && axil_req.awaddr == REG_STATUS &&
                         axil_req.wstrb[0] && axil_req.wdata[3]) begin
                overrun <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/uart_rx.sv
// 8 data bits LSB first, one stop bit; frames are offered for one clk with no back-pressure
`default_nettype none
`timescale 1ns/1ps

module uart_rx (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   baud_tick,
    input  logic                   rx,
    input  uart_pkg::parity_mode_e parity_mode,
    output logic                   rx_valid,
    output uart_pkg::rx_frame_t    rx_frame
);
    import uart_pkg::*;

    logic              rx_meta;
    logic              rx_sync;
    logic              rx_prev;
    line_state_e       state;
    logic [TICK_W-1:0] tick_cnt;
    logic [2:0]        bit_idx;
    logic [7:0]        shreg;
    logic [7:0]        shreg_next;
    logic              use_parity;
    logic              parity_exp;
    logic              parity_err;
    logic              sample_mid;
    logic              sample_end;
    logic              last_bit;

    assign use_parity = (parity_mode == PARITY_ODD) || (parity_mode == PARITY_EVEN);
    assign sample_mid = baud_tick && (tick_cnt == TICK_W'(OVERSAMPLE / 2 - 1));
    assign sample_end = baud_tick && (tick_cnt == TICK_W'(OVERSAMPLE - 1));
    assign shreg_next = {rx_sync, shreg[7:1]};
    assign last_bit   = (state == S_DATA) && sample_end && (bit_idx == 3'd7);

    // Two-flop synchronizer plus one more flop for edge detection
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= S_IDLE;
            tick_cnt <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            // Wraps to 0 on each sample tick
            if (baud_tick) begin
                tick_cnt <= tick_cnt + 1'b1;
            end
            case (state)
                S_IDLE: begin
                    if (rx_prev && !rx_sync) begin
                        state    <= S_START;
                        tick_cnt <= '0;
                    end
                end
                S_START: begin
                    if (sample_mid) begin
                        // Glitch, not a start bit
                        state    <= rx_sync ? S_IDLE : S_DATA;
                        tick_cnt <= '0;
                        bit_idx  <= '0;
                    end
                end
                S_DATA: begin
                    if (sample_end) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= use_parity ? S_PARITY : S_STOP;
                        end
                    end
                end
                S_PARITY: begin
                    if (sample_end) begin
                        state <= S_STOP;
                    end
                end
                S_STOP: begin
                    if (sample_end) begin
                        state    <= S_IDLE;
                        rx_valid <= 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Datapath
    always_ff @(posedge clk) begin
        if (state == S_DATA && sample_end) begin
            shreg <= shreg_next;
        end
        if (last_bit) begin
            parity_exp <= (^shreg_next) ^ (parity_mode == PARITY_ODD);
            parity_err <= 1'b0;
        end
        if (state == S_PARITY && sample_end) begin
            parity_err <= (rx_sync != parity_exp);
        end
        if (state == S_STOP && sample_end) begin
            rx_frame.data       <= shreg;
            rx_frame.parity_err <= parity_err;
            rx_frame.frame_err  <= !rx_sync;
        end
    end

endmodule

`default_nettype wire

//--- verilog/uart_top.sv
// UART with AXI4-Lite registers; rx is asynchronous and synchronized inside the receiver
`default_nettype none
`timescale 1ns/1ps

module uart_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  uart_axi_pkg::axil_req_t axil_req,
    output uart_axi_pkg::axil_rsp_t axil_rsp,
    input  logic                    rx,
    output logic                    tx
);
    import uart_pkg::*;

    parity_mode_e     parity_mode;
    logic [DIV_W-1:0] divisor;
    logic             baud_tick;

    logic             rx_valid;
    rx_frame_t        rx_frame;
    logic             rx_push_ready;
    logic             rx_pop_valid;
    rx_frame_t        rx_pop_data;
    logic             rx_pop_ready;

    logic             tx_push_valid;
    logic [7:0]       tx_push_data;
    logic             tx_push_ready;
    logic             tx_empty;
    logic             tx_busy;
    logic             byte_valid;
    logic [7:0]       byte_data;
    logic             byte_ready;

    uart_regs u_regs (
        .clk           (clk),
        .rst_n         (rst_n),
        .axil_req      (axil_req),
        .axil_rsp      (axil_rsp),
        .parity_mode   (parity_mode),
        .divisor       (divisor),
        .tx_push_valid (tx_push_valid),
        .tx_push_data  (tx_push_data),
        .tx_push_ready (tx_push_ready),
        .tx_empty      (tx_empty),
        .tx_busy       (tx_busy),
        .rx_pop_valid  (rx_pop_valid),
        .rx_pop_data   (rx_pop_data),
        .rx_pop_ready  (rx_pop_ready),
        .rx_valid      (rx_valid),
        .rx_push_ready (rx_push_ready)
    );

    uart_baud_gen u_baud_gen (
        .clk       (clk),
        .rst_n     (rst_n),
        .divisor   (divisor),
        .baud_tick (baud_tick)
    );

    uart_rx u_rx (
        .clk         (clk),
        .rst_n       (rst_n),
        .baud_tick   (baud_tick),
        .rx          (rx),
        .parity_mode (parity_mode),
        .rx_valid    (rx_valid),
        .rx_frame    (rx_frame)
    );

    // Receive path, overflow is caught in the register block
    uart_fifo #(
        .entry_t (rx_frame_t),
        .DEPTH   (RX_DEPTH)
    ) u_rx_fifo (
        .clk        (clk),
        .rst_n      (rst_n),
        .push_valid (rx_valid),
        .push_data  (rx_frame),
        .push_ready (rx_push_ready),
        .pop_valid  (rx_pop_valid),
        .pop_data   (rx_pop_data),
        .pop_ready  (rx_pop_ready),
        .empty      (),
        .full       ()
    );

    uart_fifo #(
        .entry_t (logic [7:0]),
        .DEPTH   (TX_DEPTH)
    ) u_tx_fifo (
        .clk        (clk),
        .rst_n      (rst_n),
        .push_valid (tx_push_valid),
        .push_data  (tx_push_data),
        .push_ready (tx_push_ready),
        .pop_valid  (byte_valid),
        .pop_data   (byte_data),
        .pop_ready  (byte_ready),
        .empty      (tx_empty),
        .full       ()
    );

    uart_tx u_tx (
        .clk         (clk),
        .rst_n       (rst_n),
        .baud_tick   (baud_tick),
        .parity_mode (parity_mode),
        .byte_valid  (byte_valid),
        .byte_data   (byte_data),
        .byte_ready  (byte_ready),
        .busy        (tx_busy),
        .tx          (tx)
    );

endmodule

`default_nettype wire

//--- verilog/uart_tx.sv
// Parity mode is latched with each byte; a byte waits for the next baud tick before the start bit
`default_nettype none
`timescale 1ns/1ps

module uart_tx (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   baud_tick,
    input  uart_pkg::parity_mode_e parity_mode,
    input  logic                   byte_valid,
    input  logic [7:0]             byte_data,
    output logic                   byte_ready,
    output logic                   busy,
    output logic                   tx
);
    import uart_pkg::*;

    line_state_e       state;
    logic [TICK_W-1:0] tick_cnt;
    logic [2:0]        bit_idx;
    logic              loaded;
    logic [7:0]        shreg;
    logic              par_bit;
    logic              use_par;
    logic              bit_end;

    assign byte_ready = (state == S_IDLE) && !loaded;
    assign busy       = loaded || (state != S_IDLE);
    assign bit_end    = baud_tick && (tick_cnt == TICK_W'(OVERSAMPLE - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= S_IDLE;
            tick_cnt <= '0;
            bit_idx  <= '0;
            loaded   <= 1'b0;
            tx       <= 1'b1;
        end else begin
            if (byte_valid && byte_ready) begin
                loaded <= 1'b1;
            end
            if (baud_tick && state != S_IDLE) begin
                tick_cnt <= tick_cnt + 1'b1;
            end
            case (state)
                S_IDLE: begin
                    if (loaded && baud_tick) begin
                        state    <= S_START;
                        loaded   <= 1'b0;
                        tick_cnt <= '0;
                        tx       <= 1'b0;
                    end
                end
                S_START: begin
                    if (bit_end) begin
                        state   <= S_DATA;
                        bit_idx <= '0;
                        tx      <= shreg[0];
                    end
                end
                S_DATA: begin
                    if (bit_end) begin
                        if (bit_idx == 3'd7) begin
                            state <= use_par ? S_PARITY : S_STOP;
                            tx    <= use_par ? par_bit : 1'b1;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                            tx      <= shreg[bit_idx + 3'd1];
                        end
                    end
                end
                S_PARITY: begin
                    if (bit_end) begin
                        state <= S_STOP;
                        tx    <= 1'b1;
                    end
                end
                S_STOP: begin
                    if (bit_end) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Byte and its parity bit captured on acceptance
    always_ff @(posedge clk) begin
        if (byte_valid && byte_ready) begin
            shreg   <= byte_data;
            par_bit <= (^byte_data) ^ (parity_mode == PARITY_ODD);
            use_par <= (parity_mode == PARITY_ODD) || (parity_mode == PARITY_EVEN);
        end
    end

endmodule

`default_nettype wire
